/* Bender.yml */
package:
  name: proc_regfile

sources:
  # Synthesizable design
  - include_dirs:
      - .
    files:
      - proc_regfile_pkg.sv
      - register_file.sv
      - idb_bus_router.sv
      - proc_regfile_top.sv

  # Simulation only
  - target: simulation
    include_dirs:
      - .
    files:
      - proc_regfile_tb.sv

/* idb_bus_router.sv */
//////////////////////////////
// IDB router, 74245 pair and
// OR merge of bus sources
//////////////////////////////
module idb_bus_router
  import proc_regfile_pkg::*;
(
  input  logic      bedo_n,        // Direction, low is B to A
  input  logic      estof_n,       // Transceiver enable, active low
  input  idb_word_t idb_in,        // External IDB
  input  idb_word_t fidb_cga_out,  // Gate-array side bus out
  input  idb_word_t rd_data,       // Register file read data
  output idb_word_t idb_out,       // IDB driven back out
  output idb_word_t fidb_cga_in,   // Gate-array side bus in
  output idb_word_t wr_data        // Register file write data
);

  idb_word_t tx_a_in;              // A side input, IDB plus RAM
  idb_word_t tx_b_in;              // B side input, gate array
  idb_word_t tx_a_out;             // A side output
  idb_word_t tx_b_out;             // B side output
  logic      tx_oe;                // Both bytes enabled
  logic      tx_b2a;               // Gate array drives IDB

  // Both byte lanes share DIR and OE, so one 16-bit stage
  assign tx_oe  = ~estof_n;
  assign tx_b2a = ~bedo_n;

  // Side inputs
  assign tx_a_in = idb_in | rd_data;            // Wired-OR on the IDB side
  assign tx_b_in = fidb_cga_out;

  // Direction and enable
  assign tx_a_out = (tx_oe && tx_b2a)  ? tx_b_in : '0;   // CGA to IDB
  assign tx_b_out = (tx_oe && !tx_b2a) ? tx_a_in : '0;   // IDB to CGA

  // Bus merge
  assign fidb_cga_in = tx_b_out;
  assign idb_out     = rd_data | tx_a_out;      // RAM or transceiver
  assign wr_data     = idb_in | tx_a_out;       // Write sees both IDB sources

  // Disabled transceiver leaves only the direct paths
  // on all three outputs
  always_comb begin
    if (estof_n) begin
      a_tx_off : assert final (
        (fidb_cga_in == '0) && (idb_out == rd_data) && (wr_data == idb_in)
      ) else $error("idb_bus_router transceiver active with estof_n high");
    end
  end

endmodule

/* proc_regfile.f */
+incdir+.
proc_regfile_pkg.sv
register_file.sv
idb_bus_router.sv
proc_regfile_top.sv
proc_regfile_tb.sv

/* proc_regfile_input.txt */
// test idbs lba laa bank wrtrf wrfstb term_n bedo_n estof_n idb_in fidb_cga_out
// then expected idb_out fidb_cga_in rrf_n, all hex, one cycle per line
// Test 1, idle after reset with transceivers off
1 00 0 0 0 0 0 1 1 1 0000 0000 0000 0000 1
1 00 0 0 0 0 0 1 1 1 A5A5 0000 0000 0000 1
1 00 0 0 0 0 0 1 0 1 0000 1234 0000 0000 1
// Test 2, write banks 1 and 2 at B=3 A=7, read back one cycle late
2 00 3 7 1 1 1 1 1 1 BEEF 0000 0000 0000 1
2 05 3 7 1 0 0 1 1 1 0000 0000 0000 0000 0
2 00 0 0 0 0 0 1 1 1 0000 0000 BEEF 0000 1
2 00 0 0 0 0 0 1 1 1 0000 0000 0000 0000 1
2 00 3 7 2 1 1 1 1 1 1357 0000 0000 0000 1
2 05 3 7 1 0 0 1 1 1 0000 0000 0000 0000 0
2 05 3 7 2 0 0 1 1 1 0000 0000 BEEF 0000 0
2 00 0 0 0 0 0 1 1 1 0000 0000 1357 0000 1
// Test 3, blocked writes at bank 0 B=A A=5
3 00 A 5 0 1 1 1 1 1 1111 0000 0000 0000 1
3 00 A 5 0 1 0 1 1 1 2222 0000 0000 0000 1
3 00 A 5 0 1 1 0 1 1 3333 0000 0000 0000 1
3 00 A 5 0 0 1 1 1 1 4444 0000 0000 0000 1
3 05 A 5 0 0 0 1 1 1 0000 0000 0000 0000 0
3 00 0 0 0 0 0 1 1 1 0000 0000 1111 0000 1
3 05 A 5 0 1 0 1 1 1 5555 0000 0000 0000 0
3 00 0 0 0 0 0 1 1 1 0000 0000 1111 0000 1
3 05 A 5 0 1 1 1 1 1 6666 0000 0000 0000 0
3 00 0 0 0 0 0 1 1 1 0000 0000 0000 0000 1
3 05 A 5 0 0 0 1 1 1 0000 0000 0000 0000 0
3 00 0 0 0 0 0 1 1 1 0000 0000 6666 0000 1
// Test 4, gate array onto IDB, write at bank 3 B=1 A=2
4 00 0 0 0 0 0 1 0 0 0000 0F00 0F00 0000 1
4 00 1 2 3 1 1 1 0 0 00F0 0F00 0F00 0000 1
4 05 1 2 3 0 0 1 1 1 0000 0000 0000 0000 0
4 00 0 0 0 0 0 1 0 0 0000 0001 0FF1 0000 1
4 00 0 0 0 0 0 1 1 1 0000 0000 0000 0000 1
// Test 5, IDB and read data toward the gate array
5 00 0 0 0 0 0 1 1 0 00A0 5000 0000 00A0 1
5 05 3 7 1 0 0 1 1 0 0000 0000 0000 0000 0
5 00 0 0 0 0 0 1 1 0 0100 0000 BEEF BFEF 1
5 00 0 0 0 1 1 1 1 0 0A0A 0000 0000 0A0A 1
5 05 0 0 0 0 0 1 1 1 0000 0000 0000 0000 0
5 00 0 0 0 0 0 1 1 1 0000 0000 0A0A 0000 1

/* proc_regfile_params.svh */
//////////////////////////////
// Register file widths, depths and source codes
//////////////////////////////
`ifndef PROC_REGFILE_PARAMS_SVH
`define PROC_REGFILE_PARAMS_SVH

// Internal data bus word
`define PRF_DATA_W 16

// Register-file address, 1 spare + 2 bank + 4 B + 4 A
`define PRF_ADDR_W 11

// Two 2Kx8 RAMs merged into one 16-bit array
`define PRF_DEPTH 2048

// Microcode control store word
`define PRF_CSW_W 64

// CSIDBS value that selects the register file (REG)
`define PRF_IDBS_REG 5

`endif

/* proc_regfile_pkg.sv */
//////////////////////////////
// Register file shared types
//////////////////////////////
`include "proc_regfile_params.svh"

package proc_regfile_pkg;

  // One IDB word
  typedef logic [`PRF_DATA_W-1:0] idb_word_t;

  // CSIDBS field, only REG matters here
  typedef enum logic [4:0] {
    IDBS_OTHER = 5'd0,           // Any non-register source
    IDBS_REG   = `PRF_IDBS_REG   // Register file drives IDB
  } idbs_src_e;

  // Control store word, MSB first
  typedef struct packed {
    logic [19:0] spare_63_44;    // Unused microcode bits
    logic [1:0]  misc;           // CSMIS, bits 43..42
    idbs_src_e   idbs;           // CSIDBS, bits 41..37
    logic [4:0]  comm;           // CSCOMM, bits 36..32
    logic [11:0] spare_31_20;    // Unused microcode bits
    logic [3:0]  lba;            // B operand, bits 19..16
    logic [15:0] spare_15_0;     // Unused microcode bits
  } cs_word_t;

  // Register-file address as wired on the sheet
  typedef struct packed {
    logic       spare;           // A10 tied to ground
    logic [1:0] bank;            // RF bank from gate array
    logic [3:0] lba;             // B operand nibble
    logic [3:0] laa;             // A operand nibble
  } rf_addr_t;

endpackage

/* proc_regfile_tb.sv */
//////////////////////////////
// Register file top testbench,
// file-driven steps and bank sweep
//////////////////////////////
module proc_regfile_tb
  import proc_regfile_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_COLS     = 15;         // Fields per step line
  localparam int N_STEPS    = 34;         // Step lines in the input file
  localparam int SETTLE_MAX = 20;         // Cycles allowed after reset
  localparam int SWEEPS     = 3;          // Rounds of the bank sweep

  logic       sysclk;
  logic       rst_n;
  cs_word_t   csbits;
  logic [3:0] laa;
  logic [1:0] rf_bank;
  logic       wrtrf;
  logic       wrfstb;
  logic       term_n;
  logic       bedo_n;
  logic       estof_n;
  idb_word_t  idb_in;
  idb_word_t  fidb_cga_out;
  idb_word_t  idb_out;
  idb_word_t  fidb_cga_in;
  logic [3:0] lba;
  logic       rrf_n;

  logic [31:0] vec [N_STEPS*N_COLS];      // Raw step table
  logic [31:0] rng_state;                 // xorshift state
  idb_word_t   model [4];                 // Expected word per bank
  int          err_count;
  int          check_count;
  int          test_errs;                 // Error count at test start
  int          test_checks;               // Check count at test start
  int          tests_done;

  proc_regfile_top proc_regfile_top_i (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .csbits       (csbits),
    .laa          (laa),
    .rf_bank      (rf_bank),
    .wrtrf        (wrtrf),
    .wrfstb       (wrfstb),
    .term_n       (term_n),
    .bedo_n       (bedo_n),
    .estof_n      (estof_n),
    .idb_in       (idb_in),
    .fidb_cga_out (fidb_cga_out),
    .idb_out      (idb_out),
    .fidb_cga_in  (fidb_cga_in),
    .lba          (lba),
    .rrf_n        (rrf_n)
  );

  initial begin
    sysclk = 1'b0;
    forever #50 sysclk = ~sysclk;         // 100 ns period
  end

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // Apply one cycle of inputs just after the edge
  task automatic drive_step(input logic [4:0] idbs, input logic [3:0] b_op,
                            input logic [3:0] a_op, input logic [1:0] bank,
                            input logic wr, input logic stb, input logic term,
                            input logic dir_n, input logic oe_n,
                            input idb_word_t bus, input idb_word_t cga);
    @(posedge sysclk);
    #5;
    csbits      = '0;
    csbits.idbs = idbs_src_e'(idbs);
    csbits.lba  = b_op;
    laa          = a_op;
    rf_bank      = bank;
    wrtrf        = wr;
    wrfstb       = stb;
    term_n       = term;
    bedo_n       = dir_n;
    estof_n      = oe_n;
    idb_in       = bus;
    fidb_cga_out = cga;
  endtask

  // Outputs are settled by mid-cycle
  task automatic check_outputs(input idb_word_t exp_idb, input idb_word_t exp_cga,
                               input logic exp_rrf, input logic [3:0] exp_lba);
    @(negedge sysclk);
    compare("idb_out", exp_idb, idb_out);
    compare("fidb_cga_in", exp_cga, fidb_cga_in);
    compare("rrf_n", exp_rrf, rrf_n);
    compare("lba", exp_lba, lba);
  endtask

  task automatic finish_test(input int num);
    $display("Test %0d done: %0d checks, %0d errors", num,
             check_count - test_checks, err_count - test_errs);
    tests_done++;
    test_checks = check_count;
    test_errs   = err_count;
  endtask

  task automatic wait_settled();
    int   n;
    logic settled;
    n       = 0;
    settled = 1'b0;
    while (!settled && n < SETTLE_MAX) begin
      settled = (rrf_n === 1'b1) && (idb_out === '0) && (fidb_cga_in === '0);
      if (!settled) begin
        @(negedge sysclk);
        n++;
      end
    end
    if (!settled) begin
      err_count++;
      $display("Timeout: outputs did not reach idle values after reset");
    end
  endtask

  // Walk the step table, one line per cycle
  task automatic run_file();
    int s;
    int base;
    int cur_test;
    cur_test = vec[0];
    for (s = 0; s < N_STEPS; s++) begin
      base = s * N_COLS;
      if (vec[base] != cur_test) begin
        finish_test(cur_test);            // Test number changed
        cur_test = vec[base];
      end
      drive_step(vec[base+1][4:0], vec[base+2][3:0], vec[base+3][3:0],
                 vec[base+4][1:0], vec[base+5][0], vec[base+6][0], vec[base+7][0],
                 vec[base+8][0], vec[base+9][0], vec[base+10][15:0], vec[base+11][15:0]);
      check_outputs(vec[base+12][15:0], vec[base+13][15:0], vec[base+14][0],
                    vec[base+2][3:0]);
    end
    finish_test(cur_test);
  endtask

  // Same nibbles in all four banks, pipelined read-back
  task automatic bank_sweep(input int rounds);
    logic [3:0] a_op;
    logic [3:0] b_op;
    idb_word_t  exp_word;
    int         r;
    int         b;
    for (r = 0; r < rounds; r++) begin
      rng_state = xorshift32(rng_state);
      a_op      = rng_state[3:0];
      b_op      = rng_state[7:4];
      for (b = 0; b < 4; b++) begin
        rng_state = xorshift32(rng_state);
        model[b]  = rng_state[15:0];
        drive_step(IDBS_OTHER, b_op, a_op, 2'(b), 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
                   model[b], '0);
        check_outputs('0, '0, 1'b1, b_op);  // No read before a write
      end
      for (b = 0; b < 5; b++) begin
        if (b < 4) begin
          drive_step(IDBS_REG, b_op, a_op, 2'(b), 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, '0, '0);
        end else begin
          drive_step(IDBS_OTHER, b_op, a_op, 2'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, '0, '0);
        end
        if (b == 0) begin
          exp_word = '0;                  // Previous cycle wrote
        end else begin
          exp_word = model[b-1];          // One cycle behind the read
        end
        check_outputs(exp_word, '0, (b < 4) ? 1'b0 : 1'b1, b_op);
      end
    end
  endtask

  initial begin
    err_count    = 0;
    check_count  = 0;
    test_errs    = 0;
    test_checks  = 0;
    tests_done   = 0;
    rng_state    = 32'd16;
    rst_n        = 1'b0;
    csbits       = '0;
    laa          = '0;
    rf_bank      = '0;
    wrtrf        = 1'b0;
    wrfstb       = 1'b0;
    term_n       = 1'b1;
    bedo_n       = 1'b1;
    estof_n      = 1'b1;                  // Transceivers off
    idb_in       = '0;
    fidb_cga_out = '0;
    repeat (8) @(posedge sysclk);
    #5;
    rst_n = 1'b1;
    wait_settled();

    $readmemh("proc_regfile_input.txt", vec);
    if ($isunknown(vec[0]) || $isunknown(vec[N_STEPS*N_COLS-1])) begin
      err_count++;
      $display("Input file missing or shorter than %0d steps", N_STEPS);
    end else begin
      run_file();
    end

    bank_sweep(SWEEPS);
    finish_test(6);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, check_count,
             err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* proc_regfile_top.sv */
//////////////////////////////
// Processor register file top,
// RAM plus IDB transceivers
//////////////////////////////
module proc_regfile_top
  import proc_regfile_pkg::*;
(
  input  logic       sysclk,        // System clock
  input  logic       rst_n,         // Async reset, active low

  // Microcode and gate-array controls
  input  cs_word_t   csbits,        // Control store word
  input  logic [3:0] laa,           // A operand from gate array
  input  logic [1:0] rf_bank,       // Register bank from gate array
  input  logic       wrtrf,         // Write register file request
  input  logic       wrfstb,        // Write strobe
  input  logic       term_n,        // Bus cycle terminate

  // Transceiver controls
  input  logic       bedo_n,        // Gate array drives IDB when low
  input  logic       estof_n,       // Transceiver enable

  // Data buses
  input  idb_word_t  idb_in,        // External IDB in
  input  idb_word_t  fidb_cga_out,  // From gate array
  output idb_word_t  idb_out,       // External IDB out
  output idb_word_t  fidb_cga_in,   // To gate array

  // Status
  output logic [3:0] lba,           // B operand, CSBITS 19..16
  output logic       rrf_n          // Read register flag
);

  idb_word_t rd_data;               // RAM to router
  idb_word_t wr_data;               // Router to RAM

  // B operand straight from microcode
  assign lba = csbits.lba;

  register_file register_file_i (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .csbits  (csbits),
    .laa     (laa),
    .rf_bank (rf_bank),
    .wrtrf   (wrtrf),
    .wrfstb  (wrfstb),
    .term_n  (term_n),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .rrf_n   (rrf_n)
  );

  idb_bus_router idb_bus_router_i (
    .bedo_n       (bedo_n),
    .estof_n      (estof_n),
    .idb_in       (idb_in),
    .fidb_cga_out (fidb_cga_out),
    .rd_data      (rd_data),
    .idb_out      (idb_out),
    .fidb_cga_in  (fidb_cga_in),
    .wr_data      (wr_data)
  );

endmodule

/* register_file.sv */
//////////////////////////////
// Register file, 2048x16 block RAM with
// REG-source select and registered read
//////////////////////////////
`include "proc_regfile_params.svh"

module register_file
  import proc_regfile_pkg::*;
(
  input  logic       sysclk,     // System clock
  input  logic       rst_n,      // Async reset, active low
  input  cs_word_t   csbits,     // Current microcode word
  input  logic [3:0] laa,        // A operand nibble
  input  logic [1:0] rf_bank,    // Bank select
  input  logic       wrtrf,      // Write register file request
  input  logic       wrfstb,     // Write strobe
  input  logic       term_n,     // Bus cycle terminate
  input  idb_word_t  wr_data,    // Merged bus data to store
  output idb_word_t  rd_data,    // Read data, zero when idle
  output logic       rrf_n       // Read register flag
);

  logic      idbs_reg;           // Source field names the file
  logic      rf_sel;             // Chip select, was ERF_n
  logic      wr_qual;            // Qualified strobe, was TWRF_n
  logic      rf_we;              // Array write enable
  logic      rd_en;              // Array read enable
  rf_addr_t  rf_addr;            // Bank, B and A nibbles
  idb_word_t rd_q;               // RAM output register
  logic      rd_vld;             // rd_q holds a real read

  idb_word_t mem [`PRF_DEPTH];   // Storage, no reset

  // Elaboration checks on the shared types
  if ($bits(cs_word_t) != `PRF_CSW_W) begin : g_csw_chk
    $error("cs_word_t width does not match the control store word");
  end

  if ($bits(rf_addr_t) != `PRF_ADDR_W) begin : g_addr_chk
    $error("rf_addr_t width does not match the register-file address");
  end

  // Select and strobe decode
  assign idbs_reg = (csbits.idbs == IDBS_REG);   // CSIDBS = 5
  assign rrf_n    = ~idbs_reg;                   // Low while REG is source
  assign rf_sel   = idbs_reg | wrtrf;            // Includes the PAL fix
  assign wr_qual  = wrtrf & wrfstb & term_n;     // All three at once
  assign rf_we    = rf_sel & wr_qual;
  assign rd_en    = idbs_reg & ~wr_qual;         // Read only when not writing

  // Address wiring, A10 grounded
  assign rf_addr = '{
    spare: 1'b0,
    bank:  rf_bank,
    lba:   csbits.lba,
    laa:   laa
  };

  // Synchronous write port
  always_ff @(posedge sysclk) begin
    if (rf_we) begin
      mem[rf_addr] <= wr_data;                   // Store merged IDB word
    end
  end

  // Registered read port, maps onto BRAM output
  always_ff @(posedge sysclk) begin
    if (rd_en) begin
      rd_q <= mem[rf_addr];
    end
  end

  // Valid flag qualifies the held word
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld <= 1'b0;                            // Nothing read yet
    end else begin
      rd_vld <= rd_en;                           // One-cycle read latency
    end
  end

  // Zero on the bus unless the last cycle read
  assign rd_data = rd_vld ? rd_q : '0;

  // Address must be known at every write
  a_wr_addr_known : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    rf_we |-> !$isunknown(rf_addr)
  ) else $error("register_file write with unknown address %h", rf_addr);

  // Idle cycle leaves the bus clear on the next one
  a_rd_idle_zero : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    !rd_en |=> (rd_data == '0)
  ) else $error("register_file rd_data not zero after idle cycle: %h", rd_data);

endmodule
